/* Bender.yml */
package:
  name: exe_stage

export_include_dirs:
  - common

sources:
  - files:
      - common/exe_pkg.sv
      - hw/alu.sv
      - exe_stage/exe_ctrl.sv
      - exe_stage/lsu_req.sv
      - exe_stage/exe_stage.sv
  - target: simulation
    files:
      - testbench/exe_stage_chk.sv
      - testbench/tb_exe_stage.sv

/* common/exe_consts.svh */
`ifndef EXE_CONSTS_SVH
`define EXE_CONSTS_SVH

// datapath widths
`define EXE_XLEN      32
`define EXE_REG_AW    5              // register number
`define EXE_IMM_W     16
`define EXE_STRB_W    4              // one strobe per byte lane
`define EXE_SIZE_CW   2              // width of the transfer size code

// shift amount field inside the immediate
`define EXE_SA_LSB    6
`define EXE_SA_W      5

// fixed segment mapping
`define EXE_KSEG_TAG  2'b10          // addr[31:30] of kseg0 and kseg1
`define EXE_KSEG_CLR  3              // top bits dropped for unmapped segments

// transfer size codes on the data bus
`define EXE_SIZE_B    2'd0
`define EXE_SIZE_H    2'd1
`define EXE_SIZE_W    2'd2

`endif

/* common/exe_pkg.sv */
`include "exe_consts.svh"

package exe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR,  ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW,
        MEM_SB, MEM_SH,  MEM_SW
    } mem_op_e;

    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_OV,                               // trapping add/sub overflow
        EXC_ADEL,                             // misaligned load
        EXC_ADES                              // misaligned store
    } exc_e;

    typedef struct packed {
        logic [`EXE_XLEN-1:0]    pc;
        alu_op_e                 alu_op;
        logic                    src1_is_sa;
        logic                    src1_is_pc;
        logic                    src2_is_simm;
        logic                    src2_is_zimm;
        logic                    src2_is_8;
        logic                    trap_ov;     // add/sub that raises overflow
        mem_op_e                 mem_op;
        logic                    gr_we;
        logic [`EXE_REG_AW-1:0]  dest;
        logic [`EXE_IMM_W-1:0]   imm;
        logic [`EXE_XLEN-1:0]    rs_value;
        logic [`EXE_XLEN-1:0]    rt_value;
    } exe_uop_t;

    typedef struct packed {
        logic [`EXE_XLEN-1:0]    pc;
        logic [`EXE_XLEN-1:0]    result;
        mem_op_e                 mem_op;
        logic                    gr_we;
        logic [`EXE_REG_AW-1:0]  dest;
        exc_e                    exc;
    } exe_result_t;

    typedef struct packed {
        logic                    wr;
        logic [`EXE_SIZE_CW-1:0] size;
        logic [`EXE_STRB_W-1:0]  wstrb;
        logic [`EXE_XLEN-1:0]    addr;
        logic [`EXE_XLEN-1:0]    wdata;
    } data_req_t;

    typedef struct packed {
        logic                    valid;
        logic                    gr_we;
        logic                    is_load;     // decode must stall on this
        logic [`EXE_REG_AW-1:0]  dest;
        logic [`EXE_XLEN-1:0]    result;
    } bypass_t;

    function automatic logic mem_is_load(mem_op_e op);
        return op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
    endfunction

    function automatic logic mem_is_store(mem_op_e op);
        return op inside {MEM_SB, MEM_SH, MEM_SW};
    endfunction

endpackage

/* exe_stage/exe_ctrl.sv */
`timescale 1ns/1ps
`include "exe_consts.svh"

module exe_ctrl
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  exe_pkg::exe_uop_t    uop,
    output logic                 in_allowin,
    output logic                 out_valid,
    input  logic                 out_allowin,
    output logic                 stage_valid,
    output exe_pkg::exe_uop_t    held_uop,
    output logic                 advance,
    input  logic [`EXE_XLEN-1:0] alu_result,
    input  logic                 ov,
    input  logic                 mem_done,
    input  exe_pkg::exc_e        addr_exc,
    output exe_pkg::exe_result_t res,
    output exe_pkg::bypass_t     bypass
);

    logic          ready_go;
    exe_pkg::exc_e exc;

    assign ready_go   = stage_valid & mem_done;
    assign in_allowin = ~stage_valid | (ready_go & out_allowin);
    assign out_valid  = stage_valid & ready_go;
    assign advance    = out_valid & out_allowin;   // result leaves this cycle

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stage_valid <= 1'b0;
        end
        else if (in_allowin)
        begin
            stage_valid <= in_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid && in_allowin)
        begin
            held_uop <= uop;
        end
    end

    // overflow trap wins over the address check
    assign exc = (held_uop.trap_ov && ov) ? exe_pkg::EXC_OV : addr_exc;

    always_comb
    begin
        res.pc     = held_uop.pc;
        res.result = alu_result;
        res.mem_op = held_uop.mem_op;
        res.gr_we  = held_uop.gr_we;
        res.dest   = held_uop.dest;
        res.exc    = exc;
    end

    always_comb
    begin
        bypass.valid   = stage_valid;
        bypass.gr_we   = held_uop.gr_we;
        bypass.is_load = exe_pkg::mem_is_load(held_uop.mem_op);   // data not ready yet
        bypass.dest    = held_uop.dest;
        bypass.result  = alu_result;
    end

endmodule

/* exe_stage/exe_stage.sv */
`timescale 1ns/1ps
`include "exe_consts.svh"

module exe_stage
(
    input  logic                 clk,
    input  logic                 reset,
    // from decode
    input  logic                 in_valid,
    input  exe_pkg::exe_uop_t    uop,
    output logic                 in_allowin,
    // to memory stage
    output logic                 out_valid,
    output exe_pkg::exe_result_t res,
    input  logic                 out_allowin,
    // data memory request port
    output logic                 data_req,
    output exe_pkg::data_req_t   dreq,
    input  logic                 data_addr_ok,
    // forwarding to decode
    output exe_pkg::bypass_t     bypass
);

    logic                 stage_valid;
    logic                 advance;
    exe_pkg::exe_uop_t    held_uop;
    logic [`EXE_XLEN-1:0] alu_result;
    logic                 ov;
    logic                 mem_done;
    exe_pkg::exc_e        addr_exc;

    exe_ctrl u_ctrl
    (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .uop         (uop),
        .in_allowin  (in_allowin),
        .out_valid   (out_valid),
        .out_allowin (out_allowin),
        .stage_valid (stage_valid),
        .held_uop    (held_uop),
        .advance     (advance),
        .alu_result  (alu_result),
        .ov          (ov),
        .mem_done    (mem_done),
        .addr_exc    (addr_exc),
        .res         (res),
        .bypass      (bypass)
    );

    alu u_alu
    (
        .uop        (held_uop),
        .alu_result (alu_result),
        .ov         (ov)
    );

    lsu_req u_lsu
    (
        .clk          (clk),
        .reset        (reset),
        .stage_valid  (stage_valid),
        .held_uop     (held_uop),
        .alu_result   (alu_result),
        .ov           (ov),
        .advance      (advance),
        .data_req     (data_req),
        .dreq         (dreq),
        .data_addr_ok (data_addr_ok),
        .mem_done     (mem_done),
        .addr_exc     (addr_exc)
    );

endmodule

/* exe_stage/lsu_req.sv */
`timescale 1ns/1ps
`include "exe_consts.svh"

module lsu_req
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stage_valid,
    input  exe_pkg::exe_uop_t    held_uop,
    input  logic [`EXE_XLEN-1:0] alu_result,
    input  logic                 ov,
    input  logic                 advance,
    output logic                 data_req,
    output exe_pkg::data_req_t   dreq,
    input  logic                 data_addr_ok,
    output logic                 mem_done,
    output exe_pkg::exc_e        addr_exc
);

    typedef enum logic {
        IDLE,
        SENT                                       // request taken, waiting to leave
    } lsu_state_e;

    lsu_state_e                state;
    logic                      is_load;
    logic                      is_store;
    logic                      is_mem;
    logic                      is_half;
    logic                      is_word;
    logic [1:0]                offset;
    logic                      misaligned;
    logic                      no_req;
    logic                      accepted;
    logic [`EXE_XLEN-1:0]      paddr;
    logic [`EXE_SIZE_CW-1:0]   size;
    logic [`EXE_STRB_W-1:0]    strb;
    logic [`EXE_XLEN-1:0]      wdata;

    assign is_load  = exe_pkg::mem_is_load(held_uop.mem_op);
    assign is_store = exe_pkg::mem_is_store(held_uop.mem_op);
    assign is_mem   = is_load | is_store;
    assign is_half  = held_uop.mem_op inside {exe_pkg::MEM_LH, exe_pkg::MEM_LHU, exe_pkg::MEM_SH};
    assign is_word  = held_uop.mem_op inside {exe_pkg::MEM_LW, exe_pkg::MEM_SW};
    assign offset   = alu_result[1:0];

    assign misaligned = (is_half && offset[0]) || (is_word && offset != 2'b00);
    assign no_req     = misaligned | (held_uop.trap_ov & ov);   // faulting op stays off the bus

    always_comb
    begin
        addr_exc = exe_pkg::EXC_NONE;
        if (misaligned)
        begin
            addr_exc = is_load ? exe_pkg::EXC_ADEL : exe_pkg::EXC_ADES;
        end
    end

    assign data_req = stage_valid && is_mem && !no_req && state == IDLE;
    assign accepted = data_req && data_addr_ok;
    assign mem_done = !is_mem || no_req || state == SENT || accepted;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
        end
        else if (advance)
        begin
            state <= IDLE;                         // next micro-op may request
        end
        else if (accepted)
        begin
            state <= SENT;
        end
    end

    // kseg0/kseg1 drop the top bits, everything else passes through
    always_comb
    begin
        paddr = alu_result;
        if (alu_result[`EXE_XLEN-1 -: 2] == `EXE_KSEG_TAG)
        begin
            paddr[`EXE_XLEN-1 -: `EXE_KSEG_CLR] = '0;
        end
        paddr[1:0] = 2'b00;                        // word aligned bus address
    end

    always_comb
    begin
        size  = `EXE_SIZE_W;
        strb  = 4'b1111;
        wdata = held_uop.rt_value;
        case (held_uop.mem_op)
            exe_pkg::MEM_LB, exe_pkg::MEM_LBU, exe_pkg::MEM_SB:
            begin
                size  = `EXE_SIZE_B;
                strb  = 4'b0001 << offset;
                wdata = {4{held_uop.rt_value[7:0]}};    // byte on every lane
            end
            exe_pkg::MEM_LH, exe_pkg::MEM_LHU, exe_pkg::MEM_SH:
            begin
                size  = `EXE_SIZE_H;
                strb  = offset[1] ? 4'b1100 : 4'b0011;
                wdata = {2{held_uop.rt_value[15:0]}};
            end
            default:
            begin
                size  = `EXE_SIZE_W;
                strb  = 4'b1111;
                wdata = held_uop.rt_value;
            end
        endcase
    end

    always_comb
    begin
        dreq.wr    = is_store;
        dreq.size  = size;
        dreq.wstrb = is_store ? strb : '0;         // loads write nothing
        dreq.addr  = paddr;
        dreq.wdata = wdata;
    end

endmodule

/* hw/alu.sv */
`timescale 1ns/1ps
`include "exe_consts.svh"

module alu
(
    input  exe_pkg::exe_uop_t    uop,
    output logic [`EXE_XLEN-1:0] alu_result,
    output logic                 ov
);

    logic [`EXE_XLEN-1:0] src1;
    logic [`EXE_XLEN-1:0] src2;
    logic [`EXE_XLEN-1:0] sum;
    logic [`EXE_XLEN-1:0] diff;
    logic [`EXE_SA_W-1:0] shamt;
    logic                 slt;
    logic                 sltu;

    always_comb
    begin
        if (uop.src1_is_sa)
        begin
            src1 = {{(`EXE_XLEN-`EXE_SA_W){1'b0}}, uop.imm[`EXE_SA_LSB +: `EXE_SA_W]};
        end
        else if (uop.src1_is_pc)
        begin
            src1 = uop.pc;                         // link address
        end
        else
        begin
            src1 = uop.rs_value;
        end
    end

    always_comb
    begin
        if (uop.src2_is_simm)
        begin
            src2 = {{(`EXE_XLEN-`EXE_IMM_W){uop.imm[`EXE_IMM_W-1]}}, uop.imm};
        end
        else if (uop.src2_is_zimm)
        begin
            src2 = {{(`EXE_XLEN-`EXE_IMM_W){1'b0}}, uop.imm};
        end
        else if (uop.src2_is_8)
        begin
            src2 = `EXE_XLEN'(8);                  // pc+8 for links
        end
        else
        begin
            src2 = uop.rt_value;
        end
    end

    assign sum   = src1 + src2;
    assign diff  = src1 - src2;
    assign shamt = src1[`EXE_SA_W-1:0];
    assign slt   = $signed(src1) < $signed(src2);
    assign sltu  = src1 < src2;

    always_comb
    begin
        case (uop.alu_op)
            exe_pkg::ALU_ADD:  alu_result = sum;
            exe_pkg::ALU_SUB:  alu_result = diff;
            exe_pkg::ALU_SLT:  alu_result = {{(`EXE_XLEN-1){1'b0}}, slt};
            exe_pkg::ALU_SLTU: alu_result = {{(`EXE_XLEN-1){1'b0}}, sltu};
            exe_pkg::ALU_AND:  alu_result = src1 & src2;
            exe_pkg::ALU_OR:   alu_result = src1 | src2;
            exe_pkg::ALU_XOR:  alu_result = src1 ^ src2;
            exe_pkg::ALU_NOR:  alu_result = ~(src1 | src2);
            exe_pkg::ALU_SLL:  alu_result = src2 << shamt;
            exe_pkg::ALU_SRL:  alu_result = src2 >> shamt;
            exe_pkg::ALU_SRA:  alu_result = $signed(src2) >>> shamt;
            exe_pkg::ALU_LUI:  alu_result = {uop.imm, {(`EXE_XLEN-`EXE_IMM_W){1'b0}}};
            default:           alu_result = sum;
        endcase
    end

    // signed overflow, only meaningful for add and sub
    always_comb
    begin
        ov = 1'b0;
        if (uop.alu_op == exe_pkg::ALU_ADD)
        begin
            ov = (src1[`EXE_XLEN-1] == src2[`EXE_XLEN-1]) &&
                 (sum[`EXE_XLEN-1] != src1[`EXE_XLEN-1]);
        end
        else if (uop.alu_op == exe_pkg::ALU_SUB)
        begin
            ov = (src1[`EXE_XLEN-1] != src2[`EXE_XLEN-1]) &&
                 (diff[`EXE_XLEN-1] != src1[`EXE_XLEN-1]);
        end
    end

endmodule

/* sim.f */
+incdir+common
common/exe_pkg.sv
hw/alu.sv
exe_stage/exe_ctrl.sv
exe_stage/lsu_req.sv
exe_stage/exe_stage.sv
testbench/exe_stage_chk.sv
testbench/tb_exe_stage.sv

/* testbench/exe_stage_chk.sv */
`timescale 1ns/1ps

module exe_stage_chk
(
    input logic                 clk,
    input logic                 reset,
    input logic                 in_allowin,
    input logic                 out_valid,
    input logic                 out_allowin,
    input exe_pkg::exe_result_t res,
    input logic                 data_req,
    input exe_pkg::data_req_t   dreq,
    input logic                 data_addr_ok,
    input exe_pkg::bypass_t     bypass,
    input exe_pkg::exc_e        addr_exc
);

    int unsigned fail_cnt = 0;              // read by the testbench

    req_stable: assert property (@(posedge clk) disable iff (reset)
        data_req && !data_addr_ok |=> data_req && $stable(dreq))
    else
    begin
        $error("data request dropped or changed before address accept");
        fail_cnt++;
    end

    res_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_allowin |=> out_valid && $stable(res))
    else
    begin
        $error("result changed while stalled by the memory stage");
        fail_cnt++;
    end

    no_bad_req: assert property (@(posedge clk) disable iff (reset)
        data_req |-> addr_exc == exe_pkg::EXC_NONE)
    else
    begin
        $error("data request raised for a misaligned access");
        fail_cnt++;
    end

    // state right after the reset edge
    reset_idle: assert property (@(posedge clk)
        reset |=> !out_valid && !data_req && !bypass.valid && in_allowin)
    else
    begin
        $error("stage not idle after reset");
        fail_cnt++;
    end

endmodule

bind exe_stage exe_stage_chk u_chk
(
    .clk          (clk),
    .reset        (reset),
    .in_allowin   (in_allowin),
    .out_valid    (out_valid),
    .out_allowin  (out_allowin),
    .res          (res),
    .data_req     (data_req),
    .dreq         (dreq),
    .data_addr_ok (data_addr_ok),
    .bypass       (bypass),
    .addr_exc     (addr_exc)
);

/* testbench/tb_exe_stage.sv */
`timescale 1ns/1ps
`include "exe_consts.svh"

module tb_exe_stage;

    localparam logic [31:0] SEED = 32'h21d4;

    typedef struct packed {
        exe_pkg::exe_result_t res;
        logic                 is_load;
        logic                 has_req;
        exe_pkg::data_req_t   req;
    } expect_t;

    logic                 clk;
    logic                 reset;
    logic                 in_valid;
    exe_pkg::exe_uop_t    uop;
    logic                 in_allowin;
    logic                 out_valid;
    exe_pkg::exe_result_t res;
    logic                 out_allowin;
    logic                 data_req;
    exe_pkg::data_req_t   dreq;
    logic                 data_addr_ok;
    exe_pkg::bypass_t     bypass;

    exe_pkg::exe_uop_t    stim_q[$];
    expect_t              exp_q[$];
    string                name_q[$];

    logic [31:0] gen_rng  = SEED;
    logic [31:0] drv_rng  = SEED ^ 32'h0000_0001;
    logic [31:0] rsp_rng  = SEED ^ 32'h0000_0002;
    logic [31:0] bp_rng   = SEED ^ 32'h0000_0003;
    logic        in_taken  = 1'b0;     // set at posedge, read at negedge
    logic        req_taken = 1'b0;
    int unsigned cycles      = 0;
    int unsigned cycle_limit = 0;
    int unsigned sent        = 0;
    int unsigned received    = 0;
    int unsigned req_seen    = 0;      // requests for the held micro-op
    int unsigned ok_wait     = 0;
    int unsigned stall_left  = 0;

    exe_stage UUT
    (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .uop          (uop),
        .in_allowin   (in_allowin),
        .out_valid    (out_valid),
        .res          (res),
        .out_allowin  (out_allowin),
        .data_req     (data_req),
        .dreq         (dreq),
        .data_addr_ok (data_addr_ok),
        .bypass       (bypass)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // two steps, upper halves only
    function automatic logic [31:0] next_rand();
        logic [15:0] hi;
        gen_rng = lcg_next(gen_rng);
        hi      = gen_rng[31:16];
        gen_rng = lcg_next(gen_rng);
        return {hi, gen_rng[31:16]};
    endfunction

    function automatic exe_pkg::exe_uop_t new_uop();
        exe_pkg::exe_uop_t u;
        u          = '0;
        u.alu_op   = exe_pkg::ALU_ADD;
        u.mem_op   = exe_pkg::MEM_NONE;
        u.pc       = next_rand() & 32'hffff_fffc;
        u.dest     = 5'(next_rand());
        u.gr_we    = 1'(next_rand() >> 9);
        u.imm      = 16'(next_rand());
        u.rs_value = next_rand();
        u.rt_value = next_rand();
        return u;
    endfunction

    // {ov, result}
    function automatic logic [32:0] model_alu(exe_pkg::exe_uop_t u);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        longint      wide;
        logic        ov;
        a = u.src1_is_sa ? {27'd0, u.imm[10:6]} : (u.src1_is_pc ? u.pc : u.rs_value);
        if (u.src2_is_simm)
            b = {{16{u.imm[15]}}, u.imm};
        else if (u.src2_is_zimm)
            b = {16'h0000, u.imm};
        else
            b = u.src2_is_8 ? 32'd8 : u.rt_value;
        case (u.alu_op)
            exe_pkg::ALU_ADD:  r = a + b;
            exe_pkg::ALU_SUB:  r = a - b;
            exe_pkg::ALU_SLT:  r = {31'd0, $signed(a) < $signed(b)};
            exe_pkg::ALU_SLTU: r = {31'd0, a < b};
            exe_pkg::ALU_AND:  r = a & b;
            exe_pkg::ALU_OR:   r = a | b;
            exe_pkg::ALU_XOR:  r = a ^ b;
            exe_pkg::ALU_NOR:  r = ~(a | b);
            exe_pkg::ALU_SLL:  r = b << a[4:0];
            exe_pkg::ALU_SRL:  r = b >> a[4:0];
            exe_pkg::ALU_SRA:  r = $signed(b) >>> a[4:0];
            default:           r = {u.imm, 16'h0000};
        endcase
        // exact sum in 64 bits, overflow when it does not fit back in 32
        if (u.alu_op == exe_pkg::ALU_SUB)
            wide = longint'($signed(a)) - longint'($signed(b));
        else
            wide = longint'($signed(a)) + longint'($signed(b));
        ov = (u.alu_op inside {exe_pkg::ALU_ADD, exe_pkg::ALU_SUB}) &&
             (wide != longint'($signed(r)));
        return {ov, r};
    endfunction

    function automatic expect_t model_expect(exe_pkg::exe_uop_t u);
        expect_t     e;
        logic [32:0] alu;
        logic [1:0]  off;
        logic        load;
        logic        store;
        logic        bad;
        int          nbytes;
        alu    = model_alu(u);
        off    = alu[1:0];
        load   = u.mem_op inside {exe_pkg::MEM_LB, exe_pkg::MEM_LBU, exe_pkg::MEM_LH,
                                  exe_pkg::MEM_LHU, exe_pkg::MEM_LW};
        store  = u.mem_op inside {exe_pkg::MEM_SB, exe_pkg::MEM_SH, exe_pkg::MEM_SW};
        nbytes = 4;
        if (u.mem_op inside {exe_pkg::MEM_LB, exe_pkg::MEM_LBU, exe_pkg::MEM_SB})
            nbytes = 1;
        else if (u.mem_op inside {exe_pkg::MEM_LH, exe_pkg::MEM_LHU, exe_pkg::MEM_SH})
            nbytes = 2;
        bad = (load || store) && (off % nbytes) != 0;
        e            = '0;
        e.res.pc     = u.pc;
        e.res.result = alu[31:0];
        e.res.mem_op = u.mem_op;
        e.res.gr_we  = u.gr_we;
        e.res.dest   = u.dest;
        if (u.trap_ov && alu[32])
            e.res.exc = exe_pkg::EXC_OV;
        else if (bad)
            e.res.exc = load ? exe_pkg::EXC_ADEL : exe_pkg::EXC_ADES;
        else
            e.res.exc = exe_pkg::EXC_NONE;
        e.is_load  = load;
        e.has_req  = (load || store) && !bad;
        e.req.wr   = store;
        e.req.size = (nbytes == 1) ? `EXE_SIZE_B : (nbytes == 2) ? `EXE_SIZE_H : `EXE_SIZE_W;
        e.req.addr = alu[31:0];
        if (alu[31:30] == `EXE_KSEG_TAG)
            e.req.addr = {3'b000, alu[28:0]};            // kseg0/kseg1 unmapped
        e.req.addr[1:0] = 2'b00;
        for (int i = 0; i < 4; i++)
        begin
            e.req.wstrb[i]       = store && i >= off && i < off + nbytes;
            e.req.wdata[8*i +: 8] = u.rt_value[8*(i % nbytes) +: 8];   // lane replication
        end
        return e;
    endfunction

    task automatic push_uop(string name, exe_pkg::exe_uop_t u);
        stim_q.push_back(u);
        exp_q.push_back(model_expect(u));
        name_q.push_back(name);
    endtask

    task automatic add_alu_tests();
        exe_pkg::exe_uop_t u;
        for (int op = 0; op < 12; op++)
            for (int s1 = 0; s1 < 3; s1++)
                for (int s2 = 0; s2 < 4; s2++)
                begin
                    u              = new_uop();
                    u.alu_op       = exe_pkg::alu_op_e'(op);
                    u.src1_is_sa   = (s1 == 1);
                    u.src1_is_pc   = (s1 == 2);
                    u.src2_is_simm = (s2 == 1);
                    u.src2_is_zimm = (s2 == 2);
                    u.src2_is_8    = (s2 == 3);
                    push_uop($sformatf("alu %s sel %0d/%0d", u.alu_op.name(), s1, s2), u);
                end
    endtask

    task automatic add_overflow_tests();
        exe_pkg::exe_uop_t u;
        for (int k = 0; k < 40; k++)
        begin
            u         = new_uop();
            u.alu_op  = (k % 2) ? exe_pkg::ALU_SUB : exe_pkg::ALU_ADD;
            u.trap_ov = (k % 4) < 2;
            if (k < 8)
            begin
                u.rs_value = 32'h7fff_fff0 + k;          // sure overflow corners
                u.rt_value = (k % 2) ? 32'h8000_0010 : 32'h0000_0020;
            end
            push_uop($sformatf("overflow %s trap %0d #%0d", u.alu_op.name(), u.trap_ov, k), u);
        end
    endtask

    task automatic add_mem_tests();
        exe_pkg::exe_uop_t u;
        for (int pass = 0; pass < 2; pass++)
            for (int m = 1; m <= 8; m++)
                for (int off = 0; off < 4; off++)
                begin
                    u              = new_uop();
                    u.mem_op       = exe_pkg::mem_op_e'(m);
                    u.src2_is_simm = 1'b1;
                    u.imm          = u.imm & 16'hfffc;
                    u.rs_value     = {u.rs_value[31:2], 2'(off)};
                    push_uop($sformatf("mem %s off %0d", u.mem_op.name(), off), u);
                end
    endtask

    task automatic add_kseg_tests();
        exe_pkg::exe_uop_t u;
        for (int top = 0; top < 4; top++)
            for (int k = 0; k < 4; k++)
            begin
                u              = new_uop();
                u.mem_op       = (k % 2) ? exe_pkg::MEM_SW : exe_pkg::MEM_LW;
                u.src2_is_simm = 1'b1;
                u.imm          = '0;
                u.rs_value     = {2'(top), u.rs_value[29:2], 2'b00};
                push_uop($sformatf("segment %0d %s #%0d", top, u.mem_op.name(), k), u);
            end
    endtask

    task automatic abort_run(string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(string test, string field, logic [127:0] exp_v,
                                   logic [127:0] act_v);
        abort_run($sformatf("ERROR %s %s: expected %0h, actual %0h", test, field, exp_v, act_v));
    endtask

    task automatic check_request();
        expect_t e;
        string   nm;
        assert (exp_q.size() != 0) else abort_run("memory request with no micro-op in flight");
        e  = exp_q[0];
        nm = name_q[0];
        assert (e.has_req) else abort_run($sformatf("%s raised an unexpected request", nm));
        assert (req_seen == 0) else abort_run($sformatf("%s issued its request twice", nm));
        assert (dreq.wr == e.req.wr) else report_mismatch(nm, "wr", e.req.wr, dreq.wr);
        assert (dreq.size == e.req.size) else report_mismatch(nm, "size", e.req.size, dreq.size);
        assert (dreq.addr == e.req.addr) else report_mismatch(nm, "addr", e.req.addr, dreq.addr);
        assert (dreq.wstrb == e.req.wstrb)
            else report_mismatch(nm, "wstrb", e.req.wstrb, dreq.wstrb);
        assert (!e.req.wr || dreq.wdata == e.req.wdata)
            else report_mismatch(nm, "wdata", e.req.wdata, dreq.wdata);
        req_seen++;
    endtask

    task automatic check_result();
        expect_t          e;
        string            nm;
        exe_pkg::bypass_t bp;
        assert (exp_q.size() != 0) else abort_run("result with no micro-op in flight");
        e  = exp_q.pop_front();
        nm = name_q.pop_front();
        bp = {1'b1, e.res.gr_we, e.is_load, e.res.dest, e.res.result};
        assert (res.result == e.res.result)
            else report_mismatch(nm, "result", e.res.result, res.result);
        assert (res.exc == e.res.exc) else report_mismatch(nm, "exc", e.res.exc, res.exc);
        assert (res == e.res) else report_mismatch(nm, "result bundle", e.res, res);
        assert (bypass == bp) else report_mismatch(nm, "bypass", bp, bypass);
        assert (req_seen == e.has_req)
            else report_mismatch(nm, "request count", e.has_req, req_seen);
        req_seen = 0;
        received++;
    endtask

    // handshake sampling, values settle after the falling edge
    always @(posedge clk)
    begin
        in_taken  = !reset && in_valid && in_allowin;
        req_taken = !reset && data_req && data_addr_ok;
        if (!reset)
        begin
            cycles++;
            if (cycles > cycle_limit)
                abort_run($sformatf("timeout after %0d cycles with %0d of %0d results",
                                    cycles, received, stim_q.size()));
            if (UUT.u_chk.fail_cnt != 0)
                abort_run("a handshake assertion failed");
            if (req_taken)
                check_request();
            if (out_valid && out_allowin)
                check_result();
        end
    end

    // memory side accepts after 0 to 3 cycles
    always @(negedge clk)
    begin
        if (req_taken)
        begin
            rsp_rng = lcg_next(rsp_rng);
            ok_wait = rsp_rng[17:16];
        end
        if (!reset && data_req && ok_wait == 0)
            data_addr_ok = 1'b1;
        else
        begin
            data_addr_ok = 1'b0;
            if (!reset && data_req)
                ok_wait--;
        end
    end

    // random stalls from the memory stage
    always @(negedge clk)
    begin
        if (stall_left != 0)
        begin
            out_allowin = 1'b0;
            stall_left--;
        end
        else
        begin
            bp_rng      = lcg_next(bp_rng);
            out_allowin = (bp_rng[18:17] != 2'b00);
            stall_left  = out_allowin ? 0 : bp_rng[21:20];
        end
    end

    initial
    begin
        reset        = 1'b1;
        in_valid     = 1'b0;
        uop          = '0;
        out_allowin  = 1'b1;
        data_addr_ok = 1'b0;
        add_alu_tests();
        add_overflow_tests();
        add_mem_tests();
        add_kseg_tests();
        cycle_limit = stim_q.size() * 8 + 50;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (sent < stim_q.size())
        begin
            drv_rng = lcg_next(drv_rng);
            if (drv_rng[19:17] == 3'd0)
            begin
                in_valid = 1'b0;                       // occasional bubble from decode
                @(negedge clk);
            end
            in_valid = 1'b1;
            uop      = stim_q[sent];
            @(negedge clk);
            while (!in_taken)
                @(negedge clk);
            sent++;
        end
        in_valid = 1'b0;
        wait (received == stim_q.size());
        repeat (2) @(negedge clk);
        if (UUT.u_chk.fail_cnt == 0)
        begin
            $display(">>> PASS");
            $finish;
        end
        else
            abort_run("run ended with failed checks");
    end

endmodule
